// ==== ldqCfgPkg.sv ====
/*
  Size constants of the load-queue conflict tracker.
  Shared by the RTL and the testbench; import with ldqCfgPkg::*.
*/
`default_nettype none

package ldqCfgPkg;

  // even and odd line address bits
  localparam int ADDR_WIDTH = 12;

  // bank mask with the low banks in its low half
  localparam int BANK_COUNT = 8;
  localparam int BANK_HALF = 4;

  // low-byte mask
  localparam int BLOW_WIDTH = 4;

  // instruction index
  localparam int II_WIDTH = 6;

  localparam int ENTRY_COUNT = 8;
  localparam int LANE_COUNT = 2;

endpackage

`default_nettype wire

// ==== ldqTypesPkg.sv ====
/*
  Access, half-flag and entry-state types of the load queue.
  An access describes either a load held in the queue or a store being checked.
*/
`default_nettype none

package ldqTypesPkg;

  import ldqCfgPkg::*;

  // O or E picks the line and H or L the half
  typedef struct packed {
    logic isOH;
    logic isEH;
    logic isOL;
    logic isEL;
  } ldqHalves_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addrE;
    logic [ADDR_WIDTH-1:0] addrO;
    logic [BANK_COUNT-1:0] banks;
    logic [BLOW_WIDTH-1:0] bLow;
    ldqHalves_t halves;
  } ldqAccess_t;

  typedef enum logic [1:0] {
    ENTRY_FREE,
    ENTRY_LIVE,
    // load was hit by an overlapping store
    ENTRY_CONFL
  } ldqEntryState_t;

endpackage

`default_nettype wire

// ==== ldqBusIf.sv ====
/*
  Internal buses of the load queue.
  ldqNewBus carries the two allocation lanes, ldqChkBus the two store-check lanes.
  The top level drives both through src; the entries and the allocator read dst.
*/
`timescale 1ns/1ps
`default_nettype none

interface ldqNewBus import ldqCfgPkg::*, ldqTypesPkg::*; ();

  ldqAccess_t access0;
  ldqAccess_t access1;
  logic [II_WIDTH-1:0] ii0;
  logic [II_WIDTH-1:0] ii1;
  logic en0;
  logic en1;
  logic thr0;
  logic thr1;

  modport src (
    output access0, access1, ii0, ii1, en0, en1, thr0, thr1
  );

  modport dst (
    input access0, access1, ii0, ii1, en0, en1, thr0, thr1
  );

endinterface

interface ldqChkBus import ldqTypesPkg::*; ();

  ldqAccess_t chk0;
  ldqAccess_t chk1;
  logic en0;
  logic en1;

  modport src (
    output chk0, chk1, en0, en1
  );

  modport dst (
    input chk0, chk1, en0, en1
  );

endinterface

`default_nettype wire

// ==== ldqConflCheck.sv ====
/*
  Overlap test of one held load against one store access.
  Purely combinational; used per entry and per allocation lane.
*/
`timescale 1ns/1ps
`default_nettype none

module ldqConflCheck import ldqCfgPkg::*, ldqTypesPkg::*; (
  input  ldqAccess_t held,
  input  ldqAccess_t chk,
  output logic       confl
);

  logic matchE;
  logic matchO;
  logic bankL;
  logic bankH;
  logic blowHit;
  logic oddHigh;
  logic oddLow;
  logic evenHigh;
  logic evenLow;

  assign matchE = held.addrE == chk.addrE;
  assign matchO = held.addrO == chk.addrO;

  // bank overlap per half of the mask
  assign bankL = |(held.banks[BANK_HALF-1:0] & chk.banks[BANK_HALF-1:0]);
  assign bankH = |(held.banks[BANK_COUNT-1:BANK_HALF] & chk.banks[BANK_COUNT-1:BANK_HALF]);

  assign blowHit = |(held.bLow & chk.bLow);

  // both sides must touch the same half of the same line
  assign oddHigh = held.halves.isOH & chk.halves.isOH & matchO & bankH;
  assign oddLow = held.halves.isOL & chk.halves.isOL & matchO & bankL;
  assign evenHigh = held.halves.isEH & chk.halves.isEH & matchE & bankH;
  assign evenLow = held.halves.isEL & chk.halves.isEL & matchE & bankL;

  assign confl = blowHit & (oddHigh | oddLow | evenHigh | evenLow);

endmodule

`default_nettype wire

// ==== ldqAlloc.sv ====
/*
  Free-entry selection for the two allocation lanes.
  Lane 0 takes the lowest free entry, lane 1 the highest; lane 0 wins a tie.
  Also flags a new load that already overlaps a store checked in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module ldqAlloc import ldqCfgPkg::*, ldqTypesPkg::*; (
  input  logic [ENTRY_COUNT-1:0] entryFree,
  ldqNewBus.dst                  newBus,
  ldqChkBus.dst                  chkBus,
  output logic [ENTRY_COUNT-1:0] sel0,
  output logic [ENTRY_COUNT-1:0] sel1,
  output logic                   newConfl0,
  output logic                   newConfl1,
  output logic                   full
);

  logic [ENTRY_COUNT-1:0] firstFree;
  logic [ENTRY_COUNT-1:0] lastFree;

  ldqAccess_t newAcc [LANE_COUNT];
  ldqAccess_t chkAcc [LANE_COUNT];
  logic [LANE_COUNT-1:0] chkEn;
  logic [LANE_COUNT-1:0] laneHit [LANE_COUNT];

  // isolate lowest set bit
  assign firstFree = entryFree & (~entryFree + ENTRY_COUNT'(1));

  always_comb begin
    lastFree = '0;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (entryFree[i]) begin
        lastFree = '0;
        lastFree[i] = 1'b1;
      end
    end
  end

  assign sel0 = firstFree & {ENTRY_COUNT{newBus.en0}};
  // single free entry goes to lane 0
  assign sel1 = lastFree & {ENTRY_COUNT{newBus.en1}} & ~sel0;

  assign full = ~|entryFree;

  assign newAcc[0] = newBus.access0;
  assign newAcc[1] = newBus.access1;
  assign chkAcc[0] = chkBus.chk0;
  assign chkAcc[1] = chkBus.chk1;
  assign chkEn = {chkBus.en1, chkBus.en0};

  // every new lane against every check lane
  for (genvar l = 0; l < LANE_COUNT; l++) begin : newLane
    for (genvar c = 0; c < LANE_COUNT; c++) begin : chkLane
      ldqConflCheck conflCheck (
        .held  (newAcc[l]),
        .chk   (chkAcc[c]),
        .confl (laneHit[l][c])
      );
    end
  end

  assign newConfl0 = |(laneHit[0] & chkEn);
  assign newConfl1 = |(laneHit[1] & chkEn);

endmodule

`default_nettype wire

// ==== ldqEntry.sv ====
/*
  One load-queue entry.
  Holds a load's access, index and thread, tracks whether a store hit it,
  and answers retire requests by instruction index.
*/
`timescale 1ns/1ps
`default_nettype none

module ldqEntry import ldqCfgPkg::*, ldqTypesPkg::*; (
  input  logic                clk,
  input  logic                rst,
  ldqNewBus.dst               newBus,
  ldqChkBus.dst               chkBus,
  input  logic                sel0,
  input  logic                sel1,
  input  logic                newConfl0,
  input  logic                newConfl1,
  input  logic [II_WIDTH-1:0] freeIi,
  input  logic                freeEn,
  input  logic                stall,
  input  logic                except,
  input  logic                exceptThread,
  output logic                busy,
  output logic                retireHit,
  output logic                retireConfl
);

  ldqAccess_t heldAccess;
  logic [II_WIDTH-1:0] heldIi;
  logic heldThr;
  ldqEntryState_t state;

  logic chkHit0;
  logic chkHit1;
  logic chkHit;
  logic flushHit;
  logic retireMatch;

  ldqConflCheck conflCheck0 (
    .held  (heldAccess),
    .chk   (chkBus.chk0),
    .confl (chkHit0)
  );

  ldqConflCheck conflCheck1 (
    .held  (heldAccess),
    .chk   (chkBus.chk1),
    .confl (chkHit1)
  );

  assign busy = state != ENTRY_FREE;

  // any enabled store lane overlapping this load
  assign chkHit = busy & ((chkHit0 & chkBus.en0) | (chkHit1 & chkBus.en1));

  assign flushHit = except & busy & (heldThr == exceptThread);

  // flush wins over a retire in the same cycle
  assign retireMatch = freeEn & ~stall & busy & ~flushHit & (freeIi == heldIi);

  assign retireHit = retireMatch;
  assign retireConfl = retireMatch & ((state == ENTRY_CONFL) | chkHit);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ENTRY_FREE;
    end else if (flushHit) begin
      state <= ENTRY_FREE;
    end else if (sel0) begin
      state <= newConfl0 ? ENTRY_CONFL : ENTRY_LIVE;
    end else if (sel1) begin
      state <= newConfl1 ? ENTRY_CONFL : ENTRY_LIVE;
    end else if (retireMatch) begin
      state <= ENTRY_FREE;
    end else if (state == ENTRY_LIVE && chkHit && !stall) begin
      state <= ENTRY_CONFL;
    end
  end

  // payload only loads on allocation
  always_ff @(posedge clk) begin
    if (sel0) begin
      heldAccess <= newBus.access0;
      heldIi <= newBus.ii0;
      heldThr <= newBus.thr0;
    end else if (sel1) begin
      heldAccess <= newBus.access1;
      heldIi <= newBus.ii1;
      heldThr <= newBus.thr1;
    end
  end

endmodule

`default_nettype wire

// ==== ldqTop.sv ====
/*
  Load-queue conflict tracker, top level.
  Allocates up to two loads per cycle, marks loads hit by the two store-check
  lanes and reports each retire one cycle later on retireHit/retireConfl.
  full is a plain level from the current entry states.
*/
`timescale 1ns/1ps
`default_nettype none

module ldqTop import ldqCfgPkg::*, ldqTypesPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall,
  input  logic                except,
  input  logic                exceptThread,

  input  ldqAccess_t          new0Access,
  input  ldqAccess_t          new1Access,
  input  logic [II_WIDTH-1:0] new0Ii,
  input  logic [II_WIDTH-1:0] new1Ii,
  input  logic                new0En,
  input  logic                new1En,
  input  logic                new0Thr,
  input  logic                new1Thr,

  input  ldqAccess_t          chk0Access,
  input  ldqAccess_t          chk1Access,
  input  logic                chk0En,
  input  logic                chk1En,

  input  logic [II_WIDTH-1:0] freeIi,
  input  logic                freeEn,

  output logic                retireHit,
  output logic                retireConfl,
  output logic                full
);

  ldqNewBus newBus ();
  ldqChkBus chkBus ();

  logic [ENTRY_COUNT-1:0] entryBusy;
  logic [ENTRY_COUNT-1:0] sel0;
  logic [ENTRY_COUNT-1:0] sel1;
  logic [ENTRY_COUNT-1:0] retireHitVec;
  logic [ENTRY_COUNT-1:0] retireConflVec;
  logic newConfl0;
  logic newConfl1;

  assign newBus.access0 = new0Access;
  assign newBus.access1 = new1Access;
  assign newBus.ii0 = new0Ii;
  assign newBus.ii1 = new1Ii;
  assign newBus.en0 = new0En;
  assign newBus.en1 = new1En;
  assign newBus.thr0 = new0Thr;
  assign newBus.thr1 = new1Thr;

  assign chkBus.chk0 = chk0Access;
  assign chkBus.chk1 = chk1Access;
  assign chkBus.en0 = chk0En;
  assign chkBus.en1 = chk1En;

  ldqAlloc allocUnit (
    .entryFree (~entryBusy),
    .newBus    (newBus),
    .chkBus    (chkBus),
    .sel0      (sel0),
    .sel1      (sel1),
    .newConfl0 (newConfl0),
    .newConfl1 (newConfl1),
    .full      (full)
  );

  for (genvar i = 0; i < ENTRY_COUNT; i++) begin : entryGen
    ldqEntry entry (
      .clk          (clk),
      .rst          (rst),
      .newBus       (newBus),
      .chkBus       (chkBus),
      .sel0         (sel0[i]),
      .sel1         (sel1[i]),
      .newConfl0    (newConfl0),
      .newConfl1    (newConfl1),
      .freeIi       (freeIi),
      .freeEn       (freeEn),
      .stall        (stall),
      .except       (except),
      .exceptThread (exceptThread),
      .busy         (entryBusy[i]),
      .retireHit    (retireHitVec[i]),
      .retireConfl  (retireConflVec[i])
    );
  end

  // at most one entry answers a given index
  always_ff @(posedge clk) begin
    if (rst) begin
      retireHit <= 1'b0;
      retireConfl <= 1'b0;
    end else begin
      retireHit <= |retireHitVec;
      retireConfl <= |retireConflVec;
    end
  end

endmodule

`default_nettype wire

// ==== tbLdq.sv ====
/*
  Self-checking testbench for the load-queue conflict tracker.
  Replays ldqInput.txt against ldqTop, checks every retire result against the
  file and the full level against a small model of the entry array.
*/
`timescale 1ns/1ps
`default_nettype none

module tbLdq import ldqCfgPkg::*, ldqTypesPkg::*; ();

  localparam int FIELD_COUNT = 9;
  localparam int OP_MAX = 80;
  localparam int TIMEOUT_CYCLES = 1000;

  typedef enum logic [3:0] {
    OP_END = 4'd0,
    OP_ALLOC = 4'd1,
    OP_CHECK = 4'd2,
    OP_RETIRE = 4'd3,
    OP_FLUSH = 4'd4
  } tbOp_t;

  logic clk;
  logic rst;
  logic stall;
  logic except;
  logic exceptThread;
  ldqAccess_t new0Access;
  ldqAccess_t new1Access;
  ldqAccess_t chk0Access;
  ldqAccess_t chk1Access;
  logic [II_WIDTH-1:0] new0Ii;
  logic [II_WIDTH-1:0] new1Ii;
  logic [II_WIDTH-1:0] freeIi;
  logic new0En;
  logic new1En;
  logic new0Thr;
  logic new1Thr;
  logic chk0En;
  logic chk1En;
  logic freeEn;
  logic retireHit;
  logic retireConfl;
  logic full;

  logic [$bits(ldqAccess_t)-1:0] opMem [OP_MAX*FIELD_COUNT];
  logic modelBusy [ENTRY_COUNT];
  logic [II_WIDTH-1:0] modelIi [ENTRY_COUNT];
  logic modelThr [ENTRY_COUNT];
  logic [31:0] seed;
  int checks = 0;
  int errors = 0;
  int testChecks = 0;
  int testErrors = 0;
  int curTest = 0;
  int opCount = 0;

  ldqTop i_dut (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .except       (except),
    .exceptThread (exceptThread),
    .new0Access   (new0Access),
    .new1Access   (new1Access),
    .new0Ii       (new0Ii),
    .new1Ii       (new1Ii),
    .new0En       (new0En),
    .new1En       (new1En),
    .new0Thr      (new0Thr),
    .new1Thr      (new1Thr),
    .chk0Access   (chk0Access),
    .chk1Access   (chk1Access),
    .chk0En       (chk0En),
    .chk1En       (chk1En),
    .freeIi       (freeIi),
    .freeEn       (freeEn),
    .retireHit    (retireHit),
    .retireConfl  (retireConfl),
    .full         (full)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic string testLabel(input int n);
    case (n)
      1: return "allocRetire";
      2: return "laterStore";
      3: return "allocCheck";
      4: return "dualFull";
      5: return "stall";
      6: return "flush";
      default: return "unknown";
    endcase
  endfunction

  function automatic int nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'((seed >> 16) & 32'h7fff);
  endfunction

  task automatic checkEq(input string name, input logic [63:0] expVal, input logic [63:0] actVal);
    checks++;
    testChecks++;
    if (expVal !== actVal) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expVal, actVal);
      errors++;
      testErrors++;
    end
  endtask

  task automatic finishTest();
    $display("test %s: %0d checks, %0d errors", testLabel(curTest), testChecks, testErrors);
    testChecks = 0;
    testErrors = 0;
  endtask

  // lane 0 lowest free, lane 1 highest free, lane 0 wins a single free entry
  task automatic modelAlloc(input logic [7:0] ctrl, input logic [II_WIDTH-1:0] ii0,
                            input logic [II_WIDTH-1:0] ii1);
    int pick0;
    int pick1;
    pick0 = -1;
    pick1 = -1;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (!modelBusy[i]) begin
        if (pick0 < 0) begin
          pick0 = i;
        end
        pick1 = i;
      end
    end
    if (!ctrl[0]) begin
      pick0 = -1;
    end
    if (!ctrl[1] || pick1 == pick0) begin
      pick1 = -1;
    end
    if (pick0 >= 0) begin
      modelBusy[pick0] = 1'b1;
      modelIi[pick0] = ii0;
      modelThr[pick0] = ctrl[5];
    end
    if (pick1 >= 0) begin
      modelBusy[pick1] = 1'b1;
      modelIi[pick1] = ii1;
      modelThr[pick1] = ctrl[6];
    end
  endtask

  task automatic modelFree(input tbOp_t op, input logic [7:0] ctrl, input logic [II_WIDTH-1:0] ii);
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (op == OP_RETIRE && !ctrl[4] && modelBusy[i] && modelIi[i] == ii) begin
        modelBusy[i] = 1'b0;
      end
      if (op == OP_FLUSH && modelBusy[i] && modelThr[i] == ctrl[7]) begin
        modelBusy[i] = 1'b0;
      end
    end
  endtask

  function automatic logic modelFull();
    logic allBusy;
    allBusy = 1'b1;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      allBusy &= modelBusy[i];
    end
    return allBusy;
  endfunction

  // drive one operation for a cycle and sample after the next edge
  task automatic runOp(input int base);
    tbOp_t op;
    logic [7:0] ctrl;
    logic [3:0] expBits;
    logic [II_WIDTH-1:0] ii0;
    logic [II_WIDTH-1:0] ii1;
    string label;
    op = tbOp_t'(opMem[base+1][3:0]);
    ctrl = opMem[base+2][7:0];
    ii0 = opMem[base+3][II_WIDTH-1:0];
    ii1 = opMem[base+4][II_WIDTH-1:0];
    expBits = opMem[base+8][3:0];
    label = $sformatf("%s op %0d ii %0h", testLabel(curTest), int'(op), ii0);
    @(posedge clk);
    new0Access <= opMem[base+5];
    new1Access <= opMem[base+6];
    chk0Access <= opMem[base+7];
    chk1Access <= opMem[base+6];
    new0Ii <= ii0;
    new1Ii <= ii1;
    freeIi <= ii0;
    new0Thr <= ctrl[5];
    new1Thr <= ctrl[6];
    exceptThread <= ctrl[7];
    stall <= ctrl[4];
    chk0En <= ctrl[2];
    chk1En <= ctrl[3];
    new0En <= (op == OP_ALLOC) & ctrl[0];
    new1En <= (op == OP_ALLOC) & ctrl[1];
    freeEn <= op == OP_RETIRE;
    except <= op == OP_FLUSH;
    @(posedge clk);
    new0En <= 1'b0;
    new1En <= 1'b0;
    chk0En <= 1'b0;
    chk1En <= 1'b0;
    freeEn <= 1'b0;
    except <= 1'b0;
    stall <= 1'b0;
    @(negedge clk);
    if (op == OP_ALLOC) begin
      modelAlloc(ctrl, ii0, ii1);
    end
    modelFree(op, ctrl, ii0);
    if (op == OP_RETIRE) begin
      checkEq({label, " hit"}, 64'(expBits[0]), 64'(retireHit));
      checkEq({label, " confl"}, 64'(expBits[1]), 64'(retireConfl));
    end
    checkEq({label, " full"}, 64'(modelFull()), 64'(full));
  endtask

  task automatic waitReady(output bit ready);
    int cycles;
    cycles = 0;
    while ((full !== 1'b0 || retireHit !== 1'b0) && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    ready = full === 1'b0 && retireHit === 1'b0;
    if (!ready) begin
      $display("timeout: queue did not come out of reset within %0d cycles", TIMEOUT_CYCLES);
    end
  endtask

  initial begin : mainFlow
    int base;
    int idle;
    int n;
    bit done;
    bit ready;
    for (int i = 0; i < OP_MAX*FIELD_COUNT; i++) begin
      opMem[i] = '0;
    end
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      modelBusy[i] = 1'b0;
      modelIi[i] = '0;
      modelThr[i] = 1'b0;
    end
    $readmemh("ldqInput.txt", opMem);
    seed = 32'd85920;
    rst <= 1'b1;
    stall <= 1'b0;
    except <= 1'b0;
    exceptThread <= 1'b0;
    new0Access <= '0;
    new1Access <= '0;
    chk0Access <= '0;
    chk1Access <= '0;
    new0Ii <= '0;
    new1Ii <= '0;
    freeIi <= '0;
    new0En <= 1'b0;
    new1En <= 1'b0;
    new0Thr <= 1'b0;
    new1Thr <= 1'b0;
    chk0En <= 1'b0;
    chk1En <= 1'b0;
    freeEn <= 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    waitReady(ready);
    done = !ready;
    n = 0;
    while (!done && n < OP_MAX) begin
      base = n * FIELD_COUNT;
      if (tbOp_t'(opMem[base+1][3:0]) == OP_END) begin
        done = 1'b1;
      end else begin
        if (int'(opMem[base][7:0]) != curTest) begin
          if (curTest != 0) begin
            finishTest();
          end
          curTest = int'(opMem[base][7:0]);
        end
        runOp(base);
        opCount++;
        // idle gap of 0 to 3 cycles
        idle = nextRand() % 4;
        repeat (idle) @(posedge clk);
      end
      n++;
    end
    if (curTest != 0) begin
      finishTest();
    end
    if (ready && opCount == 0) begin
      $display("no operations were read from ldqInput.txt");
    end
    $display("%0d operations, %0d checks, %0d errors", opCount, checks, errors);
    if (ready && opCount > 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ldqInput.txt ====
// one operation per line: test op ctrl ii0 ii1 acc0 acc1 chk exp
// op 1 alloc, 2 check, 3 retire (index in ii0), 4 flush, 0 end of list
// ctrl bits: 0 new0En, 1 new1En, 2 chk0En, 3 chk1En, 4 stall, 5 thr0, 6 thr1, 7 exceptThread
// access: addrE(3) addrO(3) banks(2) bLow(1) halves(1), halves OH EH OL EL from bit 3 down
// chk drives check lane 0, acc1 also drives check lane 1; exp bit 0 hit, bit 1 conflict
1 1 01 01 00 100200F0FF 0000000000 0000000000 0
1 1 03 02 03 100210F0FF 100220F0FF 0000000000 0
1 3 00 02 00 0000000000 0000000000 0000000000 1
1 3 00 01 00 0000000000 0000000000 0000000000 1
1 3 00 03 00 0000000000 0000000000 0000000000 1
1 3 00 09 00 0000000000 0000000000 0000000000 0
2 1 01 10 00 100200F018 0000000000 0000000000 0
2 2 04 00 00 0000000000 0000000000 1002001018 0
2 3 00 10 00 0000000000 0000000000 0000000000 3
2 1 01 11 00 1002000F12 0000000000 0000000000 0
2 2 08 00 00 0000000000 1002000112 0000000000 0
2 3 00 11 00 0000000000 0000000000 0000000000 3
2 1 01 12 00 100200F014 0000000000 0000000000 0
2 2 04 00 00 0000000000 0000000000 1009992014 0
2 3 00 12 00 0000000000 0000000000 0000000000 3
2 1 01 13 00 1002000F11 0000000000 0000000000 0
2 2 04 00 00 0000000000 0000000000 1007770411 0
2 3 00 13 00 0000000000 0000000000 0000000000 3
2 1 01 14 00 100200F018 0000000000 0000000000 0
2 2 04 00 00 0000000000 0000000000 1002011018 0
2 2 04 00 00 0000000000 0000000000 1002000118 0
2 2 04 00 00 0000000000 0000000000 1002001028 0
2 3 00 14 00 0000000000 0000000000 0000000000 1
3 1 05 20 00 100200F018 0000000000 1002001018 0
3 1 06 00 21 0000000000 1002000F12 1002000112 0
3 1 05 22 00 100200F018 0000000000 1002011018 0
3 3 00 20 00 0000000000 0000000000 0000000000 3
3 3 00 21 00 0000000000 0000000000 0000000000 3
3 3 00 22 00 0000000000 0000000000 0000000000 1
4 1 03 30 31 100200F0FF 100300F0FF 0000000000 0
4 1 03 32 33 100200F0FF 100300F0FF 0000000000 0
4 1 03 34 35 100200F0FF 100300F0FF 0000000000 0
4 1 03 36 37 100200F0FF 100300F0FF 0000000000 0
4 1 01 38 00 100400F0FF 0000000000 0000000000 0
4 3 00 38 00 0000000000 0000000000 0000000000 0
4 3 00 30 00 0000000000 0000000000 0000000000 1
4 1 03 39 3A 100200F0FF 100300F0FF 0000000000 0
4 3 00 3A 00 0000000000 0000000000 0000000000 0
4 3 00 39 00 0000000000 0000000000 0000000000 1
4 3 00 31 00 0000000000 0000000000 0000000000 1
4 3 00 32 00 0000000000 0000000000 0000000000 1
4 3 00 33 00 0000000000 0000000000 0000000000 1
4 3 00 34 00 0000000000 0000000000 0000000000 1
4 3 00 35 00 0000000000 0000000000 0000000000 1
4 3 00 36 00 0000000000 0000000000 0000000000 1
4 3 00 37 00 0000000000 0000000000 0000000000 1
5 1 01 40 00 100200F018 0000000000 0000000000 0
5 2 14 00 00 0000000000 0000000000 1002001018 0
5 3 10 40 00 0000000000 0000000000 0000000000 0
5 3 00 40 00 0000000000 0000000000 0000000000 1
6 1 43 50 51 100200F0FF 100300F0FF 0000000000 0
6 1 21 52 00 100500F0FF 0000000000 0000000000 0
6 1 01 53 00 100600F0FF 0000000000 0000000000 0
6 4 80 00 00 0000000000 0000000000 0000000000 0
6 3 00 51 00 0000000000 0000000000 0000000000 0
6 3 00 52 00 0000000000 0000000000 0000000000 0
6 3 00 50 00 0000000000 0000000000 0000000000 1
6 3 00 53 00 0000000000 0000000000 0000000000 1
0 0 00 00 00 0000000000 0000000000 0000000000 0

// ==== all.f ====
ldqCfgPkg.sv
ldqTypesPkg.sv
ldqBusIf.sv
ldqConflCheck.sv
ldqAlloc.sv
ldqEntry.sv
ldqTop.sv
tbLdq.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --timescale 1ns/1ps --top-module tbLdq -f all.f > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/VtbLdq > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
